/* common/gpu_defs.svh */
`ifndef GPU_DEFS_SVH
`define GPU_DEFS_SVH

// pixel and framebuffer sizes
`define GPU_PIX_W       8
`define GPU_NUM_PIX     64
`define GPU_PIX_ADDR_W  6

`define GPU_NUM_CORES   2

`define GPU_APB_ADDR_W  12

// apb register map
`define GPU_REG_CTRL    12'h000 // write 1 to start a task
`define GPU_REG_OP      12'h004
`define GPU_REG_OPERAND 12'h008
`define GPU_REG_STATUS  12'h00C // bit 0 busy, bits 15:8 task count

// framebuffer window, one pixel per word, read only
`define GPU_FB_BASE     12'h100

`endif

/* common/gpu_pkg.sv */
package gpu_pkg;

    // per-pixel shading operation, selected through the OP register
    typedef enum logic [1:0] {
        OP_ADD  = 2'd0, // index + operand
        OP_XOR  = 2'd1, // index ^ operand
        OP_MUL  = 2'd2, // low byte of index * operand
        OP_FILL = 2'd3  // operand only
    } op_e;

    // pixel walker inside each shader core
    typedef enum logic [1:0] {
        CORE_IDLE  = 2'd0,
        CORE_CALC  = 2'd1,
        CORE_WRITE = 2'd2 // holds the write request until granted
    } core_state_e;

    // task scheduler
    typedef enum logic [1:0] {
        SCHED_IDLE     = 2'd0,
        SCHED_DISPATCH = 2'd1, // start pulse to the cores
        SCHED_RUN      = 2'd2
    } sched_state_e;

endpackage

/* hdl/task_scheduler.sv */
`timescale 1ns/1ps
`include "gpu_defs.svh"

module task_scheduler
    import gpu_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`GPU_APB_ADDR_W-1:0] paddr,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [31:0]                pwdata,
    output logic [31:0]                prdata,
    output logic                       pready,
    output logic                       pslverr,
    output logic                       core_start,
    output op_e                        op,
    output logic [`GPU_PIX_W-1:0]      operand,
    input  logic [`GPU_NUM_CORES-1:0]  core_done,
    output logic                       fb_rd_en,
    output logic [`GPU_PIX_ADDR_W-1:0] fb_rd_addr,
    input  logic [`GPU_PIX_W-1:0]      fb_rd_data
);

    sched_state_e               state;
    logic [`GPU_NUM_CORES-1:0]  done_seen; // cores finished in this task
    logic [7:0]                 task_cnt;
    logic                       fb_wait;
    logic                       busy;
    logic                       access;
    logic                       err;
    logic                       wr_ok;
    logic                       is_ctrl;
    logic                       is_op;
    logic                       is_operand;
    logic                       is_status;
    logic                       is_fb;
    logic [`GPU_APB_ADDR_W-1:0] fb_off;

    assign fb_off     = paddr - `GPU_FB_BASE;
    assign is_ctrl    = (paddr == `GPU_REG_CTRL);
    assign is_op      = (paddr == `GPU_REG_OP);
    assign is_operand = (paddr == `GPU_REG_OPERAND);
    assign is_status  = (paddr == `GPU_REG_STATUS);
    assign is_fb      = (paddr >= `GPU_FB_BASE) && (paddr[1:0] == 2'b00)
                     && (fb_off < `GPU_APB_ADDR_W'(4 * `GPU_NUM_PIX));

    assign busy   = (state != SCHED_IDLE);
    assign access = psel && penable;

    assign err = !(is_ctrl || is_op || is_operand || is_status || is_fb)
              || (pwrite && (is_status || is_fb))
              || (pwrite && busy && (is_ctrl || is_op || is_operand));

    // framebuffer reads wait one cycle for the memory and all else is zero wait
    assign pready  = access && (!(is_fb && !pwrite) || fb_wait);
    assign pslverr = pready && err;
    assign wr_ok   = pready && pwrite && !err;

    assign fb_rd_en   = access && is_fb && !pwrite && !fb_wait;
    assign fb_rd_addr = fb_off[`GPU_PIX_ADDR_W+1:2];

    assign core_start = (state == SCHED_DISPATCH);

    always_comb begin
        prdata = '0;
        if (pready && !pwrite && !err) begin
            if (is_op)
                prdata[1:0] = op;
            else if (is_operand)
                prdata[`GPU_PIX_W-1:0] = operand;
            else if (is_status) begin
                prdata[0]    = busy;
                prdata[15:8] = task_cnt;
            end else if (is_fb)
                prdata[`GPU_PIX_W-1:0] = fb_rd_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= SCHED_IDLE;
            done_seen <= '0;
            task_cnt  <= '0;
            fb_wait   <= 1'b0;
            op        <= OP_ADD;
            operand   <= '0;
        end else begin
            fb_wait   <= fb_rd_en;
            done_seen <= done_seen | core_done;
            if (wr_ok && is_op)
                op <= op_e'(pwdata[1:0]);
            if (wr_ok && is_operand)
                operand <= pwdata[`GPU_PIX_W-1:0];
            case (state)
                SCHED_IDLE: begin
                    if (wr_ok && is_ctrl && pwdata[0]) begin
                        state     <= SCHED_DISPATCH;
                        done_seen <= '0;
                    end
                end
                SCHED_DISPATCH: state <= SCHED_RUN;
                SCHED_RUN: begin
                    if (&done_seen) begin // both halves written
                        state    <= SCHED_IDLE;
                        task_cnt <= task_cnt + 8'd1;
                    end
                end
                default: state <= SCHED_IDLE;
            endcase
        end
    end

    // the cores see a fixed task while they run
    ap_task_locked: assert property (@(posedge clk) disable iff (!rst_n)
        busy |=> $stable(op) && $stable(operand));

endmodule

/* core/shader_core.sv */
`timescale 1ns/1ps
`include "gpu_defs.svh"

module shader_core
    import gpu_pkg::*;
#(
    parameter int CORE_ID = 0 // first pixel, then every GPU_NUM_CORES-th
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       core_start,
    input  op_e                        op,
    input  logic [`GPU_PIX_W-1:0]      operand,
    output logic                       wr_valid,
    output logic [`GPU_PIX_ADDR_W-1:0] wr_addr,
    output logic [`GPU_PIX_W-1:0]      wr_data,
    input  logic                       wr_ready,
    output logic                       core_done
);

    localparam logic [`GPU_PIX_ADDR_W-1:0] FIRST_IDX = `GPU_PIX_ADDR_W'(CORE_ID);
    localparam logic [`GPU_PIX_ADDR_W-1:0] LAST_IDX  =
        `GPU_PIX_ADDR_W'(`GPU_NUM_PIX - `GPU_NUM_CORES + CORE_ID);
    localparam logic [`GPU_PIX_ADDR_W-1:0] STEP      = `GPU_PIX_ADDR_W'(`GPU_NUM_CORES);

    core_state_e                 state;
    logic [`GPU_PIX_ADDR_W-1:0]  pix_idx;
    logic [`GPU_PIX_W-1:0]       pix_val;
    logic [`GPU_PIX_W-1:0]       result;
    logic                        last_pix;

    assign pix_val = {{(`GPU_PIX_W - `GPU_PIX_ADDR_W){1'b0}}, pix_idx};

    always_comb begin
        case (op)
            OP_ADD:  result = pix_val + operand;
            OP_XOR:  result = pix_val ^ operand;
            OP_MUL:  result = pix_val * operand; // 8-bit context keeps the low byte
            default: result = operand;           // fill
        endcase
    end

    assign wr_valid  = (state == CORE_WRITE);
    assign wr_addr   = pix_idx;
    assign last_pix  = (pix_idx == LAST_IDX);
    assign core_done = wr_valid && wr_ready && last_pix;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= CORE_IDLE;
            pix_idx <= FIRST_IDX;
        end else begin
            case (state)
                CORE_IDLE: begin
                    if (core_start) begin
                        pix_idx <= FIRST_IDX;
                        state   <= CORE_CALC;
                    end
                end
                CORE_CALC: state <= CORE_WRITE;
                CORE_WRITE: begin
                    if (wr_ready) begin
                        if (last_pix)
                            state <= CORE_IDLE;
                        else begin
                            pix_idx <= pix_idx + STEP;
                            state   <= CORE_CALC;
                        end
                    end
                end
                default: state <= CORE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == CORE_CALC)
            wr_data <= result;
    end

    // request stays put while the arbiter holds it off
    ap_wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wr_valid && !wr_ready |=> wr_valid && $stable(wr_addr) && $stable(wr_data));

endmodule

/* sh_mem/sh_mem.sv */
`timescale 1ns/1ps
`include "gpu_defs.svh"

module sh_mem (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`GPU_NUM_CORES-1:0]  wr_valid,
    input  logic [`GPU_PIX_ADDR_W-1:0] wr_addr0,
    input  logic [`GPU_PIX_W-1:0]      wr_data0,
    input  logic [`GPU_PIX_ADDR_W-1:0] wr_addr1,
    input  logic [`GPU_PIX_W-1:0]      wr_data1,
    output logic [`GPU_NUM_CORES-1:0]  wr_ready,
    input  logic                       fb_rd_en,
    input  logic [`GPU_PIX_ADDR_W-1:0] fb_rd_addr,
    output logic [`GPU_PIX_W-1:0]      fb_rd_data
);

    logic                  prio;    // core that wins the next collision
    logic                  collide;
    logic [`GPU_PIX_W-1:0] fb_mem [`GPU_NUM_PIX];

    assign collide = &wr_valid;

    always_comb begin
        wr_ready = '0;
        if (collide)
            wr_ready[prio] = 1'b1;
        else
            wr_ready = wr_valid; // at most one requester
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            prio <= 1'b0;
        else if (collide)
            prio <= ~prio;
    end

    // framebuffer comes out of reset black
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `GPU_NUM_PIX; i++)
                fb_mem[i] <= '0;
        end else if (wr_ready[0]) begin
            fb_mem[wr_addr0] <= wr_data0;
        end else if (wr_ready[1]) begin
            fb_mem[wr_addr1] <= wr_data1;
        end
    end

    // host read data is valid the cycle after fb_rd_en
    always_ff @(posedge clk) begin
        if (fb_rd_en)
            fb_rd_data <= fb_mem[fb_rd_addr];
    end

    ap_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(wr_ready));

endmodule

/* hdl/gpu_top.sv */
`timescale 1ns/1ps
`include "gpu_defs.svh"

module gpu_top
    import gpu_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`GPU_APB_ADDR_W-1:0] paddr,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [31:0]                pwdata,
    output logic [31:0]                prdata,
    output logic                       pready,
    output logic                       pslverr
);

    logic                       core_start;
    op_e                        op;
    logic [`GPU_PIX_W-1:0]      operand;
    logic [`GPU_NUM_CORES-1:0]  core_done;
    logic [`GPU_NUM_CORES-1:0]  wr_valid;
    logic [`GPU_NUM_CORES-1:0]  wr_ready;
    logic [`GPU_PIX_ADDR_W-1:0] wr_addr0;
    logic [`GPU_PIX_ADDR_W-1:0] wr_addr1;
    logic [`GPU_PIX_W-1:0]      wr_data0;
    logic [`GPU_PIX_W-1:0]      wr_data1;
    logic                       fb_rd_en;
    logic [`GPU_PIX_ADDR_W-1:0] fb_rd_addr;
    logic [`GPU_PIX_W-1:0]      fb_rd_data;

    task_scheduler sched (
        .clk        (clk),
        .rst_n      (rst_n),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .core_start (core_start),
        .op         (op),
        .operand    (operand),
        .core_done  (core_done),
        .fb_rd_en   (fb_rd_en),
        .fb_rd_addr (fb_rd_addr),
        .fb_rd_data (fb_rd_data)
    );

    // even pixels
    shader_core #(.CORE_ID(0)) core0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .core_start (core_start),
        .op         (op),
        .operand    (operand),
        .wr_valid   (wr_valid[0]),
        .wr_addr    (wr_addr0),
        .wr_data    (wr_data0),
        .wr_ready   (wr_ready[0]),
        .core_done  (core_done[0])
    );

    // odd pixels
    shader_core #(.CORE_ID(1)) core1 (
        .clk        (clk),
        .rst_n      (rst_n),
        .core_start (core_start),
        .op         (op),
        .operand    (operand),
        .wr_valid   (wr_valid[1]),
        .wr_addr    (wr_addr1),
        .wr_data    (wr_data1),
        .wr_ready   (wr_ready[1]),
        .core_done  (core_done[1])
    );

    sh_mem sh_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_valid   (wr_valid),
        .wr_addr0   (wr_addr0),
        .wr_data0   (wr_data0),
        .wr_addr1   (wr_addr1),
        .wr_data1   (wr_data1),
        .wr_ready   (wr_ready),
        .fb_rd_en   (fb_rd_en),
        .fb_rd_addr (fb_rd_addr),
        .fb_rd_data (fb_rd_data)
    );

endmodule

/* tests/tb_gpu.sv */
`timescale 1ns/1ps
`include "gpu_defs.svh"

module tb_gpu
    import gpu_pkg::*;
();

    localparam int NUM_ENTRIES = 6;
    localparam int RUN_CYCLES  = 32 * 3 + 4; // worst case per task
    localparam int MAX_CYCLES  =
        NUM_ENTRIES * (RUN_CYCLES + `GPU_NUM_PIX * 4 + 40) + 200;

    logic                       clk;
    logic                       rst_n;
    logic [`GPU_APB_ADDR_W-1:0] paddr;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [31:0]                pwdata;
    logic [31:0]                prdata;
    logic                       pready;
    logic                       pslverr;

    op_e                   tbl_op      [NUM_ENTRIES];
    logic [`GPU_PIX_W-1:0] tbl_operand [NUM_ENTRIES];
    logic                  tbl_rand    [NUM_ENTRIES]; // operand drawn from the lcg
    logic [31:0]           lcg_state = 32'd45026;
    int                    cycle_cnt = 0;

    gpu_top DUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > MAX_CYCLES) begin
            $display("timeout: run did not end within %0d cycles", MAX_CYCLES);
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // expected pixel value from the shading rules
    function automatic logic [7:0] expected_pixel(input int idx, input op_e op,
                                                  input logic [7:0] operand);
        logic [7:0] idx8;
        idx8 = 8'(idx);
        case (op)
            OP_ADD:  return idx8 + operand;
            OP_XOR:  return idx8 ^ operand;
            OP_MUL:  return 8'((16'(idx8) * 16'(operand)) & 16'h00FF);
            default: return operand;
        endcase
    endfunction

    task automatic check_val(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic fill_table();
        tbl_op      = '{OP_ADD, OP_XOR, OP_MUL, OP_FILL, OP_ADD, OP_MUL};
        tbl_operand = '{8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'hFF};
        tbl_rand    = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0};
        for (int k = 0; k < NUM_ENTRIES; k++) begin
            if (tbl_rand[k]) begin
                lcg_state = lcg_next(lcg_state);
                tbl_operand[k] = lcg_state[23:16];
            end
        end
    endtask

    // access phase ends on the edge after pready is seen at the falling edge
    task automatic finish_access(output logic [31:0] data, output logic err,
                                 output int waits);
        waits = 0;
        @(negedge clk);
        while (!pready) begin
            waits++;
            @(negedge clk);
        end
        data = prdata;
        err  = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [`GPU_APB_ADDR_W-1:0] addr,
                             input logic [31:0] data, output logic err);
        logic [31:0] unused_rd;
        int          waits;
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= 1'b1;
        pwdata  <= data;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        finish_access(unused_rd, err, waits);
        check_val($sformatf("wait states writing 0x%0h", addr), 32'd0, 32'(waits));
    endtask

    task automatic apb_read(input logic [`GPU_APB_ADDR_W-1:0] addr,
                            output logic [31:0] data, output logic err);
        int waits;
        int exp_waits;
        // one wait state inside the framebuffer window, none elsewhere
        exp_waits = (addr >= `GPU_FB_BASE && addr < `GPU_FB_BASE + 4 * `GPU_NUM_PIX) ? 1 : 0;
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= 1'b0;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        finish_access(data, err, waits);
        check_val($sformatf("wait states reading 0x%0h", addr), 32'(exp_waits), 32'(waits));
    endtask

    function automatic logic [`GPU_APB_ADDR_W-1:0] fb_addr(input int idx);
        return `GPU_FB_BASE + `GPU_APB_ADDR_W'(4 * idx);
    endfunction

    task automatic run_entry(input int n);
        logic [31:0] rdata;
        logic        err;
        apb_write(`GPU_REG_OP, 32'(tbl_op[n]), err);
        check_val($sformatf("entry %0d op write slverr", n), 32'd0, 32'(err));
        apb_write(`GPU_REG_OPERAND, 32'(tbl_operand[n]), err);
        check_val($sformatf("entry %0d operand write slverr", n), 32'd0, 32'(err));
        apb_read(`GPU_REG_OP, rdata, err);
        check_val($sformatf("entry %0d op readback", n), 32'(tbl_op[n]), rdata);
        apb_read(`GPU_REG_OPERAND, rdata, err);
        check_val($sformatf("entry %0d operand readback", n), 32'(tbl_operand[n]), rdata);
        apb_write(`GPU_REG_CTRL, 32'd1, err);
        check_val($sformatf("entry %0d start slverr", n), 32'd0, 32'(err));

        // registers are locked while the cores run
        apb_write(`GPU_REG_OP, 32'(~tbl_op[n]), err);
        check_val($sformatf("entry %0d op write while busy", n), 32'd1, 32'(err));
        apb_read(`GPU_REG_OP, rdata, err);
        check_val($sformatf("entry %0d op kept while busy", n), 32'(tbl_op[n]), rdata);

        do begin
            apb_read(`GPU_REG_STATUS, rdata, err);
        end while (rdata[0]);
        check_val($sformatf("entry %0d task count", n), 32'(n + 1), 32'(rdata[15:8]));

        for (int p = 0; p < `GPU_NUM_PIX; p++) begin
            apb_read(fb_addr(p), rdata, err);
            check_val($sformatf("entry %0d pixel %0d", n, p),
                      32'(expected_pixel(p, tbl_op[n], tbl_operand[n])), rdata);
        end
    endtask

    initial begin
        logic [31:0] rdata;
        logic        err;
        rst_n   = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        fill_table();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        apb_read(fb_addr(5), rdata, err);
        check_val("pixel 5 after reset", 32'd0, rdata);

        for (int i = 0; i < NUM_ENTRIES; i++)
            run_entry(i);

        apb_read(12'h040, rdata, err);
        check_val("unmapped read slverr", 32'd1, 32'(err));
        apb_write(`GPU_FB_BASE, 32'h5A, err);
        check_val("framebuffer write slverr", 32'd1, 32'(err));
        apb_read(fb_addr(0), rdata, err); // must still hold the last task's value
        check_val("pixel 0 after rejected write",
                  32'(expected_pixel(0, tbl_op[NUM_ENTRIES-1],
                                     tbl_operand[NUM_ENTRIES-1])), rdata);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* sim.f */
+incdir+common
common/gpu_pkg.sv
hdl/task_scheduler.sv
core/shader_core.sv
sh_mem/sh_mem.sv
hdl/gpu_top.sv
tests/tb_gpu.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_gpu
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_STR  ?= Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_STR)" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
